// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   ////////////////////////////////////////
   // Instruction word
   ////////////////////////////////////////

   // Low two bits are always 2'b11 for RV32I, so they are not stored
   typedef logic [31:2] instr_t;

   // Major opcodes, instruction bits 6 to 2
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,
      OPC_OP_IMM = 5'b00100,
      OPC_AUIPC  = 5'b00101,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000,
      OPC_JALR   = 5'b11001,
      OPC_JAL    = 5'b11011,
      OPC_SYSTEM = 5'b11100
   } opcode_e;

   ////////////////////////////////////////
   // Pre-decode results
   ////////////////////////////////////////

   // Control flow class
   typedef enum logic [1:0] {
      BJ_NONE   = 2'd0,
      BJ_BRANCH = 2'd1,
      BJ_JAL    = 2'd2,
      BJ_JALR   = 2'd3
   } branch_jump_op_e;

   // Immediate format
   typedef enum logic [2:0] {
      IMM_I    = 3'd0,
      IMM_S    = 3'd1,
      IMM_B    = 3'd2,
      IMM_U    = 3'd3,
      IMM_J    = 3'd4,
      IMM_NONE = 3'd7
   } imm_src_e;

   // addi x0, x0, 0 without the low two bits
   localparam instr_t INSTR_NOP = 30'h0000_0004;

endpackage

`default_nettype wire

// ==== logic/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

   ////////////////////////////////////////
   // Front-end address and data types
   ////////////////////////////////////////

   // Program counter in words, byte offset dropped
   typedef logic [31:2] word_addr_t;

   // Fully sign-extended immediate, byte units
   typedef logic [31:0] imm_t;

   // Step of the fetch counter
   localparam word_addr_t WORD_STEP = 30'd1;

endpackage

`default_nettype wire

// ==== logic/stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One pre-decoded instruction between fetch and decode
interface stage_if;
   import isa_pkg::*;
   import frontend_pkg::*;

   instr_t          instr;
   word_addr_t      pc;
   branch_jump_op_e branch_jump_op;
   imm_src_e        imm_src;

   modport producer (
      output instr,
      output pc,
      output branch_jump_op,
      output imm_src
   );

   modport consumer (
      input instr,
      input pc,
      input branch_jump_op,
      input imm_src
   );

endinterface

`default_nettype wire

// ==== logic/quick_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module quick_decoder (
   input  isa_pkg::opcode_e         opcode_i,
   output isa_pkg::branch_jump_op_e branch_jump_op_o,
   output isa_pkg::imm_src_e        imm_src_o
);
   import isa_pkg::*;

   // Opcode alone decides class and format
   always_comb begin
      branch_jump_op_o = BJ_NONE;
      imm_src_o        = IMM_NONE;
      case (opcode_i)
         OPC_LOAD,
         OPC_OP_IMM,
         OPC_SYSTEM: begin
            imm_src_o = IMM_I;
         end
         OPC_JALR: begin
            branch_jump_op_o = BJ_JALR;
            imm_src_o        = IMM_I;
         end
         OPC_STORE: begin
            imm_src_o = IMM_S;
         end
         OPC_BRANCH: begin
            branch_jump_op_o = BJ_BRANCH;
            imm_src_o        = IMM_B;
         end
         OPC_LUI,
         OPC_AUIPC: begin
            imm_src_o = IMM_U;
         end
         OPC_JAL: begin
            branch_jump_op_o = BJ_JAL;
            imm_src_o        = IMM_J;
         end
         // Register-register ops carry no immediate
         default: begin
            branch_jump_op_o = BJ_NONE;
            imm_src_o        = IMM_NONE;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/instruction_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_memory #(
   parameter int MEM_DEPTH   = 256,
   parameter int WAIT_CYCLES = 2
) (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    load_en_i,
   input  frontend_pkg::word_addr_t load_addr_i,
   input  isa_pkg::instr_t         load_data_i,
   input  frontend_pkg::word_addr_t fetch_addr_i,
   output isa_pkg::instr_t         read_data_o,
   output logic                    read_ready_o
);
   import isa_pkg::*;
   import frontend_pkg::*;

   localparam int IDX_W = $clog2(MEM_DEPTH);
   localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
   localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_CYCLES);
   // First cycle after an address change already counts
   localparam logic [CNT_W-1:0] RESTART = CNT_W'((WAIT_CYCLES > 0) ? 1 : 0);

   instr_t           mem [MEM_DEPTH];
   word_addr_t       last_addr_q;
   logic [CNT_W-1:0] wait_cnt_q;
   logic             addr_changed;

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (load_en_i) begin
         mem[load_addr_i[IDX_W+1:2]] <= load_data_i;
      end
   end

   assign read_data_o = mem[fetch_addr_i[IDX_W+1:2]];

   ////////////////////////////////////////
   // Wait state counter
   ////////////////////////////////////////

   assign addr_changed = (fetch_addr_i != last_addr_q);

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         last_addr_q <= '0;
         wait_cnt_q  <= '0;
      end else begin
         last_addr_q <= fetch_addr_i;
         if (addr_changed) begin
            wait_cnt_q <= RESTART;
         end else if (wait_cnt_q < WAIT_LAST) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
         end
      end
   end

   // Zero wait states answer in the same cycle
   assign read_ready_o = addr_changed ? (WAIT_CYCLES == 0) : (wait_cnt_q == WAIT_LAST);

endmodule

`default_nettype wire

// ==== logic/instruction_fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch_stage (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     stall_i,
   input  logic                     redirect_i,
   input  frontend_pkg::word_addr_t redirect_target_i,
   output frontend_pkg::word_addr_t fetch_addr_o,
   input  isa_pkg::instr_t          read_data_i,
   input  logic                     read_ready_i,
   stage_if.producer                out
);
   import isa_pkg::*;
   import frontend_pkg::*;

   word_addr_t      fetch_pc_q;
   instr_t          instr_q;
   word_addr_t      pc_q;
   branch_jump_op_e bj_op_q;
   imm_src_e        imm_src_q;

   branch_jump_op_e bj_op;
   imm_src_e        imm_src;
   logic            take_word;

   quick_decoder u_quick_decoder (
      .opcode_i         (opcode_e'(read_data_i[6:2])),
      .branch_jump_op_o (bj_op),
      .imm_src_o        (imm_src)
   );

   // Redirect beats a ready word
   assign take_word = !stall_i && !redirect_i && read_ready_i;

   ////////////////////////////////////////
   // Fetch counter and stage register
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         fetch_pc_q <= '0;
         instr_q    <= INSTR_NOP;
         bj_op_q    <= BJ_NONE;
         imm_src_q  <= IMM_NONE;
      end else if (!stall_i) begin
         if (redirect_i) begin
            fetch_pc_q <= redirect_target_i;
            instr_q    <= INSTR_NOP;
            bj_op_q    <= BJ_NONE;
            imm_src_q  <= IMM_NONE;
         end else if (read_ready_i) begin
            fetch_pc_q <= fetch_pc_q + WORD_STEP;
            instr_q    <= read_data_i;
            bj_op_q    <= bj_op;
            imm_src_q  <= imm_src;
         end else begin
            // Memory still waiting
            instr_q   <= INSTR_NOP;
            bj_op_q   <= BJ_NONE;
            imm_src_q <= IMM_NONE;
         end
      end
   end

   // pc of the accepted word, meaningless on bubbles
   always_ff @(posedge clk_i) begin
      if (take_word) begin
         pc_q <= fetch_pc_q;
      end
   end

   assign fetch_addr_o       = fetch_pc_q;
   assign out.instr          = instr_q;
   assign out.pc             = pc_q;
   assign out.branch_jump_op = bj_op_q;
   assign out.imm_src        = imm_src_q;

endmodule

`default_nettype wire

// ==== logic/immediate_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module immediate_decode_stage (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      stall_i,
   stage_if.consumer                 in,
   input  logic                      ext_redirect_i,
   input  frontend_pkg::word_addr_t  ext_target_i,
   output logic                      redirect_o,
   output frontend_pkg::word_addr_t  redirect_target_o,
   output isa_pkg::instr_t           out_instr_o,
   output frontend_pkg::word_addr_t  out_pc_o,
   output isa_pkg::branch_jump_op_e  out_branch_jump_op_o,
   output isa_pkg::imm_src_e         out_imm_src_o,
   output frontend_pkg::imm_t        out_imm_o
);
   import isa_pkg::*;
   import frontend_pkg::*;

   instr_t     w;
   imm_t       imm_value;
   logic       jal_redirect;
   word_addr_t jal_target;
   logic       capture;

   assign w = in.instr;

   ////////////////////////////////////////
   // Immediate generation
   ////////////////////////////////////////

   always_comb begin
      case (in.imm_src)
         IMM_I: imm_value = {{20{w[31]}}, w[31:20]};
         IMM_S: imm_value = {{20{w[31]}}, w[31:25], w[11:7]};
         IMM_B: imm_value = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         IMM_U: imm_value = {w[31:12], 12'b0};
         IMM_J: imm_value = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         default: imm_value = '0;
      endcase
   end

   ////////////////////////////////////////
   // Redirect merge
   ////////////////////////////////////////

   // JAL resolves here, byte offset bit 1 is dropped
   assign jal_redirect = (in.branch_jump_op == BJ_JAL);
   assign jal_target   = in.pc + imm_value[31:2];

   // Back end wins over our own JAL
   assign redirect_o        = ext_redirect_i || jal_redirect;
   assign redirect_target_o = ext_redirect_i ? ext_target_i : jal_target;

   ////////////////////////////////////////
   // Output register
   ////////////////////////////////////////

   assign capture = !stall_i && !ext_redirect_i;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         out_instr_o          <= INSTR_NOP;
         out_branch_jump_op_o <= BJ_NONE;
         out_imm_src_o        <= IMM_NONE;
      end else if (!stall_i) begin
         if (ext_redirect_i) begin
            // Wrong-path word is dropped
            out_instr_o          <= INSTR_NOP;
            out_branch_jump_op_o <= BJ_NONE;
            out_imm_src_o        <= IMM_NONE;
         end else begin
            out_instr_o          <= in.instr;
            out_branch_jump_op_o <= in.branch_jump_op;
            out_imm_src_o        <= in.imm_src;
         end
      end
   end

   // Payload of the captured word
   always_ff @(posedge clk_i) begin
      if (capture) begin
         out_pc_o  <= in.pc;
         out_imm_o <= imm_value;
      end
   end

endmodule

`default_nettype wire

// ==== logic/fetch_frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_top #(
   parameter int MEM_DEPTH   = 256,
   parameter int WAIT_CYCLES = 2
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     stall_i,
   input  logic                     load_en_i,
   input  frontend_pkg::word_addr_t load_addr_i,
   input  isa_pkg::instr_t          load_data_i,
   input  logic                     branch_i,
   input  frontend_pkg::word_addr_t branch_target_i,
   output isa_pkg::instr_t          instr_o,
   output frontend_pkg::word_addr_t pc_o,
   output isa_pkg::branch_jump_op_e branch_jump_op_o,
   output isa_pkg::imm_src_e        imm_src_o,
   output frontend_pkg::imm_t       imm_o
);
   import isa_pkg::*;
   import frontend_pkg::*;

   word_addr_t fetch_addr;
   instr_t     read_data;
   logic       read_ready;
   logic       redirect;
   word_addr_t redirect_target;

   stage_if u_stage_if ();

   instruction_memory #(
      .MEM_DEPTH   (MEM_DEPTH),
      .WAIT_CYCLES (WAIT_CYCLES)
   ) u_instruction_memory (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .load_en_i    (load_en_i),
      .load_addr_i  (load_addr_i),
      .load_data_i  (load_data_i),
      .fetch_addr_i (fetch_addr),
      .read_data_o  (read_data),
      .read_ready_o (read_ready)
   );

   instruction_fetch_stage u_instruction_fetch_stage (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .stall_i           (stall_i),
      .redirect_i        (redirect),
      .redirect_target_i (redirect_target),
      .fetch_addr_o      (fetch_addr),
      .read_data_i       (read_data),
      .read_ready_i      (read_ready),
      .out               (u_stage_if.producer)
   );

   // Back-end branches enter through the decode stage merge
   immediate_decode_stage u_immediate_decode_stage (
      .clk_i                (clk_i),
      .rst_i                (rst_i),
      .stall_i              (stall_i),
      .in                   (u_stage_if.consumer),
      .ext_redirect_i       (branch_i),
      .ext_target_i         (branch_target_i),
      .redirect_o           (redirect),
      .redirect_target_o    (redirect_target),
      .out_instr_o          (instr_o),
      .out_pc_o             (pc_o),
      .out_branch_jump_op_o (branch_jump_op_o),
      .out_imm_src_o        (imm_src_o),
      .out_imm_o            (imm_o)
   );

endmodule

`default_nettype wire

// ==== verification/fetch_stage_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage_properties (
   input logic                     clk_i,
   input logic                     rst_i,
   input logic                     stall_i,
   input logic                     redirect_i,
   input isa_pkg::instr_t          instr_i,
   input frontend_pkg::word_addr_t pc_i,
   input isa_pkg::branch_jump_op_e branch_jump_op_i,
   input isa_pkg::imm_src_e        imm_src_i
);
   import isa_pkg::*;

   logic bubble;

   assign bubble = (instr_i == INSTR_NOP) && (branch_jump_op_i == BJ_NONE)
                   && (imm_src_i == IMM_NONE);

   reset_gives_bubble: assert property (@(posedge clk_i) !rst_i |=> bubble)
      else $error("fetch stage output is not a bubble after reset");

   // Redirect squashes whatever the memory offered
   redirect_gives_bubble: assert property (
      @(posedge clk_i) rst_i && !stall_i && redirect_i |=> bubble)
      else $error("fetch stage output is not a bubble after a redirect");

   stall_holds_output: assert property (
      @(posedge clk_i) rst_i && stall_i |=> $stable(instr_i) && $stable(pc_i))
      else $error("fetch stage output changed while stalled");

endmodule

bind instruction_fetch_stage fetch_stage_properties u_fetch_stage_properties (
   .clk_i            (clk_i),
   .rst_i            (rst_i),
   .stall_i          (stall_i),
   .redirect_i       (redirect_i),
   .instr_i          (instr_q),
   .pc_i             (pc_q),
   .branch_jump_op_i (bj_op_q),
   .imm_src_i        (imm_src_q)
);

`default_nettype wire

// ==== verification/fetch_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_tb;
   import isa_pkg::*;
   import frontend_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_TESTS  = 6;
   localparam int WORD_LIMIT = 40;

   logic            clk_i;
   logic            rst_i;
   logic            stall_i;
   logic            load_en_i;
   word_addr_t      load_addr_i;
   instr_t          load_data_i;
   logic            branch_i;
   word_addr_t      branch_target_i;
   instr_t          instr_o;
   word_addr_t      pc_o;
   branch_jump_op_e branch_jump_op_o;
   imm_src_e        imm_src_o;
   imm_t            imm_o;

   int              error_count;
   int              check_count;
   logic [31:0]     lcg_state;
   instr_t          program_q [$];

   // Last delivered word
   instr_t          got_instr;
   word_addr_t      got_pc;
   branch_jump_op_e got_bj;
   imm_src_e        got_src;
   imm_t            got_imm;

   fetch_frontend_top #(
      .MEM_DEPTH   (256),
      .WAIT_CYCLES (2)
   ) u_fetch_frontend_top (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .stall_i          (stall_i),
      .load_en_i        (load_en_i),
      .load_addr_i      (load_addr_i),
      .load_data_i      (load_data_i),
      .branch_i         (branch_i),
      .branch_target_i  (branch_target_i),
      .instr_o          (instr_o),
      .pc_o             (pc_o),
      .branch_jump_op_o (branch_jump_op_o),
      .imm_src_o        (imm_src_o),
      .imm_o            (imm_o)
   );

   initial clk_i = 1'b0;
   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // add rd, x0, x0 with a different rd per slot
   function automatic instr_t alu_word(input int slot);
      logic [31:0] w;
      w = 32'h0000_0033 | (32'(slot % 31 + 1) << 7);
      return w[31:2];
   endfunction

   // jal x1 with a byte offset
   function automatic instr_t jal_word(input imm_t offset);
      logic [31:0] w;
      w = {offset[20], offset[10:1], offset[11], offset[19:12], 5'd1, 7'b1101111};
      return w[31:2];
   endfunction

   // Immediate as the RV32I spec lays out each format
   function automatic imm_t expected_imm(input logic [31:0] iw, input imm_src_e fmt);
      logic signed [31:0] s;
      case (fmt)
         IMM_I: s = $signed(iw) >>> 20;
         IMM_S: s = $signed({iw[31:25], iw[11:7], 20'h0}) >>> 20;
         IMM_B: s = $signed({iw[31], iw[7], iw[30:25], iw[11:8], 20'h0}) >>> 19;
         IMM_U: s = $signed({iw[31:12], 12'h0});
         IMM_J: s = $signed({iw[31], iw[19:12], iw[20], iw[30:21], 12'h0}) >>> 11;
         default: s = '0;
      endcase
      return imm_t'(s);
   endfunction

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////

   task automatic check_instr(input string name, input instr_t got, input instr_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input word_addr_t got, input word_addr_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_imm(input string name, input imm_t got, input imm_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_predecode(input branch_jump_op_e got_op, input imm_src_e got_fmt,
                                  input branch_jump_op_e exp_op, input imm_src_e exp_fmt);
      check_count++;
      if (got_op !== exp_op || got_fmt !== exp_fmt) begin
         error_count++;
         $display("[ERROR] %0t branch_jump_op_o/imm_src_o: got %s/%s, expected %s/%s",
                  $time, got_op.name(), got_fmt.name(), exp_op.name(), exp_fmt.name());
      end
   endtask

   // Register-register word from slot at pc slot
   task automatic check_plain_word(input int slot);
      check_instr("instr_o", got_instr, alu_word(slot));
      check_addr("pc_o", got_pc, word_addr_t'(slot));
      check_predecode(got_bj, got_src, BJ_NONE, IMM_NONE);
      check_imm("imm_o", got_imm, '0);
   endtask

   ////////////////////////////////////////
   // Reset, load and stream capture
   ////////////////////////////////////////

   // Memory is written while the front end sits in reset
   task automatic load_program();
      @(negedge clk_i);
      rst_i    = 1'b0;
      stall_i  = 1'b0;
      branch_i = 1'b0;
      foreach (program_q[i]) begin
         load_en_i   = 1'b1;
         load_addr_i = word_addr_t'(i);
         load_data_i = program_q[i];
         @(negedge clk_i);
      end
      load_en_i = 1'b0;
      repeat (2) @(negedge clk_i);
      rst_i = 1'b1;
   endtask

   task automatic collect_word();
      int waited;
      waited = 0;
      do begin
         @(negedge clk_i);
         waited++;
      end while (instr_o === INSTR_NOP && waited < WORD_LIMIT);
      if (instr_o === INSTR_NOP) begin
         error_count++;
         $display("At %0t no instruction came out within %0d cycles", $time, WORD_LIMIT);
      end
      got_instr = instr_o;
      got_pc    = pc_o;
      got_bj    = branch_jump_op_o;
      got_src   = imm_src_o;
      got_imm   = imm_o;
   endtask

   task automatic fill_plain_program(input int count);
      program_q.delete();
      for (int i = 0; i < count; i++) begin
         program_q.push_back(alu_word(i));
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic test_reset_bubble();
      fill_plain_program(4);
      load_program();
      @(negedge clk_i);
      check_instr("instr_o", instr_o, INSTR_NOP);
      check_predecode(branch_jump_op_o, imm_src_o, BJ_NONE, IMM_NONE);
   endtask

   task automatic test_straight_line();
      fill_plain_program(8);
      load_program();
      for (int i = 0; i < 8; i++) begin
         collect_word();
         check_plain_word(i);
      end
   endtask

   task automatic test_immediates();
      opcode_e         opc [5];
      branch_jump_op_e exp_op [5];
      imm_src_e        exp_fmt [5];
      logic [31:0]     full [5];
      // JAL goes last so its random target is never followed
      opc     = '{OPC_OP_IMM, OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_JAL};
      exp_op  = '{BJ_NONE, BJ_NONE, BJ_BRANCH, BJ_NONE, BJ_JAL};
      exp_fmt = '{IMM_I, IMM_S, IMM_B, IMM_U, IMM_J};
      for (int round = 0; round < 3; round++) begin
         program_q.delete();
         for (int k = 0; k < 5; k++) begin
            lcg_state = lcg_next(lcg_state);
            full[k]   = {lcg_state[31:7], opc[k], 2'b11};
            program_q.push_back(full[k][31:2]);
         end
         load_program();
         for (int k = 0; k < 5; k++) begin
            collect_word();
            check_instr("instr_o", got_instr, full[k][31:2]);
            check_addr("pc_o", got_pc, word_addr_t'(k));
            check_predecode(got_bj, got_src, exp_op[k], exp_fmt[k]);
            check_imm("imm_o", got_imm, expected_imm(full[k], exp_fmt[k]));
         end
      end
   endtask

   task automatic test_jal();
      int exp_pc [5];
      exp_pc = '{0, 1, 2, 7, 8};
      fill_plain_program(10);
      // Jump forward five words from pc 2
      program_q[2] = jal_word(imm_t'(20));
      load_program();
      for (int k = 0; k < 5; k++) begin
         collect_word();
         if (exp_pc[k] == 2) begin
            check_instr("instr_o", got_instr, jal_word(imm_t'(20)));
            check_addr("pc_o", got_pc, word_addr_t'(2));
            check_predecode(got_bj, got_src, BJ_JAL, IMM_J);
            check_imm("imm_o", got_imm, imm_t'(20));
         end else begin
            check_plain_word(exp_pc[k]);
         end
      end
   endtask

   task automatic test_branch();
      fill_plain_program(16);
      load_program();
      collect_word();
      check_plain_word(0);
      collect_word();
      check_plain_word(1);
      // Word 2 sits in the fetch register two cycles later
      repeat (2) @(negedge clk_i);
      branch_i        = 1'b1;
      branch_target_i = word_addr_t'(11);
      @(negedge clk_i);
      branch_i = 1'b0;
      collect_word();
      check_plain_word(11);
      collect_word();
      check_plain_word(12);
   endtask

   task automatic test_stall();
      fill_plain_program(10);
      load_program();
      collect_word();
      check_plain_word(0);
      collect_word();
      check_plain_word(1);
      stall_i = 1'b1;
      repeat (5) begin
         @(negedge clk_i);
         check_instr("instr_o", instr_o, alu_word(1));
         check_addr("pc_o", pc_o, word_addr_t'(1));
         check_predecode(branch_jump_op_o, imm_src_o, BJ_NONE, IMM_NONE);
         check_imm("imm_o", imm_o, '0);
      end
      stall_i = 1'b0;
      for (int k = 2; k < 4; k++) begin
         collect_word();
         check_plain_word(k);
      end
   endtask

   ////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////

   initial begin
      rst_i           = 1'b0;
      stall_i         = 1'b0;
      load_en_i       = 1'b0;
      load_addr_i     = '0;
      load_data_i     = '0;
      branch_i        = 1'b0;
      branch_target_i = '0;
      error_count     = 0;
      check_count     = 0;
      lcg_state       = 32'h3cb5_99ca;

      test_reset_bubble();
      test_straight_line();
      test_immediates();
      test_jal();
      test_branch();
      test_stall();

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before the tests finished",
               NUM_TESTS * 200);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/isa_pkg.sv
logic/frontend_pkg.sv
logic/stage_if.sv
logic/quick_decoder.sv
logic/instruction_memory.sv
logic/instruction_fetch_stage.sv
logic/immediate_decode_stage.sv
logic/fetch_frontend_top.sv
verification/fetch_stage_properties.sv
verification/fetch_frontend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f compile.f \
   --top-module fetch_frontend_tb \
   -o fetch_frontend_sim \
   && ./obj_dir/fetch_frontend_sim | tee /dev/stderr \
   | grep -qF "Simulation completed successfully" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
